//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
FAIL_MSG ?= Regression failed
PASS_MSG ?= Regression passed

SRCS := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@test -f $(LOG) || { echo "no log file $(LOG)"; exit 1; }
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
logic/isa_pkg.sv
logic/core_pkg.sv
logic/core_ifs.sv
logic/alu.sv
logic/reg_file.sv
logic/data_mem.sv
logic/prog_loader.sv
logic/core_ctrl.sv
logic/cpu_top.sv
sim/tb_cpu.sv

//--- logic/alu.sv
module alu (
	input core_pkg::alu_op_e op,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [4:0] shamt,
	output logic [31:0] result,
	output logic eq
);
	always_comb begin
		case (op)
			core_pkg::ALU_ADD: result = a + b;
			core_pkg::ALU_SUB: result = a - b;
			core_pkg::ALU_AND: result = a & b;
			core_pkg::ALU_OR: result = a | b;
			core_pkg::ALU_NOR: result = ~(a | b);
			core_pkg::ALU_SLL: result = b << shamt; // shifts act on rt.
			core_pkg::ALU_SRL: result = b >> shamt;
			core_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			core_pkg::ALU_LUI: result = {b[15:0], 16'b0};
			default: result = a + b;
		endcase
	end

	assign eq = a == b; // for BEQ and BNE.
endmodule

//--- logic/core_ctrl.sv
module core_ctrl (
	input logic CLK,
	input logic rst,
	input logic load_req,
	input logic run_req,
	output core_pkg::mode_e mode,
	input logic [7:0] in_data,
	input logic in_valid,
	output logic in_ready,
	output logic [7:0] out_data,
	output logic out_valid,
	input logic out_ready,
	output logic running,
	output logic [core_pkg::IMEM_AW-1:0] fetch_addr,
	input logic [31:0] inst,
	output core_pkg::alu_op_e alu_op,
	output logic [31:0] alu_a,
	output logic [31:0] alu_b,
	input logic [31:0] alu_result,
	input logic alu_eq,
	rf_if.ctrl rf,
	dmem_if.ctrl dmem
);
	typedef enum logic [1:0] {
		WB_ALU,
		WB_LINK,
		WB_MEM,
		WB_IN
	} wb_sel_e;

	isa_pkg::opcode_e op;
	isa_pkg::funct_e funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [15:0] imm;
	logic [31:0] imm_s;
	logic [31:0] imm_z;
	logic [core_pkg::IMEM_AW-1:0] pc;
	logic [core_pkg::IMEM_AW-1:0] pc_inc;
	logic [core_pkg::IMEM_AW-1:0] pc_next;
	logic lw_phase; // high in second LW cycle.
	logic exec;
	logic stall;
	logic wb_en;
	logic [4:0] wb_addr;
	wb_sel_e wb_sel;
	logic mem_we;

	assign op = isa_pkg::opcode_e'(inst[isa_pkg::OP_LSB +: 6]);
	assign funct = isa_pkg::funct_e'(inst[isa_pkg::FUNCT_LSB +: 6]);
	assign rs = inst[isa_pkg::RS_LSB +: 5];
	assign rt = inst[isa_pkg::RT_LSB +: 5];
	assign rd = inst[isa_pkg::RD_LSB +: 5];
	assign imm = inst[isa_pkg::IMM_LSB +: 16];
	assign imm_s = {{16{imm[15]}}, imm};
	assign imm_z = {16'b0, imm};

	assign exec = mode == core_pkg::EXEC;
	assign running = exec;
	assign fetch_addr = pc;
	assign pc_inc = pc + 1'b1;

	assign in_ready = !exec || op == isa_pkg::OP_IN;
	assign out_valid = exec && op == isa_pkg::OP_OUT;
	assign out_data = rf.rd2[7:0]; // low byte of rt.

	assign rf.ra1 = rs;
	assign rf.ra2 = rt;
	assign rf.wa = wb_addr;
	assign rf.we = exec && wb_en;
	assign alu_a = rf.rd1;

	assign dmem.addr = alu_result[core_pkg::DMEM_AW-1:0]; // rs + imm.
	assign dmem.wdata = rf.rd2;
	assign dmem.we = exec && mem_we;

	always_comb begin
		alu_op = core_pkg::ALU_ADD;
		alu_b = rf.rd2;
		wb_en = 1'b0;
		wb_addr = rt;
		wb_sel = WB_ALU;
		mem_we = 1'b0;
		stall = 1'b0;
		pc_next = pc_inc;
		case (op)
			isa_pkg::OP_SPECIAL: begin
				wb_en = 1'b1;
				wb_addr = rd;
				case (funct)
					isa_pkg::FUNCT_ADD: alu_op = core_pkg::ALU_ADD;
					isa_pkg::FUNCT_SUB: alu_op = core_pkg::ALU_SUB;
					isa_pkg::FUNCT_AND: alu_op = core_pkg::ALU_AND;
					isa_pkg::FUNCT_OR: alu_op = core_pkg::ALU_OR;
					isa_pkg::FUNCT_NOR: alu_op = core_pkg::ALU_NOR;
					isa_pkg::FUNCT_SLL: alu_op = core_pkg::ALU_SLL;
					isa_pkg::FUNCT_SRL: alu_op = core_pkg::ALU_SRL;
					isa_pkg::FUNCT_SLT: alu_op = core_pkg::ALU_SLT;
					isa_pkg::FUNCT_JR: begin
						wb_en = 1'b0;
						pc_next = rf.rd1[core_pkg::IMEM_AW-1:0];
					end
					isa_pkg::FUNCT_JALR: begin
						wb_addr = 5'd31;
						wb_sel = WB_LINK;
						pc_next = rf.rd1[core_pkg::IMEM_AW-1:0];
					end
					default: wb_en = 1'b0;
				endcase
			end
			isa_pkg::OP_ADDI: begin
				alu_b = imm_s;
				wb_en = 1'b1;
			end
			isa_pkg::OP_ANDI: begin
				alu_op = core_pkg::ALU_AND;
				alu_b = imm_z;
				wb_en = 1'b1;
			end
			isa_pkg::OP_ORI: begin
				alu_op = core_pkg::ALU_OR;
				alu_b = imm_z;
				wb_en = 1'b1;
			end
			isa_pkg::OP_SLTI: begin
				alu_op = core_pkg::ALU_SLT;
				alu_b = imm_s;
				wb_en = 1'b1;
			end
			isa_pkg::OP_LUI: begin
				alu_op = core_pkg::ALU_LUI;
				alu_b = imm_z;
				wb_en = 1'b1;
			end
			isa_pkg::OP_BEQ: if (alu_eq) pc_next = pc + imm[core_pkg::IMEM_AW-1:0];
			isa_pkg::OP_BNE: if (!alu_eq) pc_next = pc + imm[core_pkg::IMEM_AW-1:0];
			isa_pkg::OP_J: pc_next = inst[core_pkg::IMEM_AW-1:0];
			isa_pkg::OP_JAL: begin
				wb_en = 1'b1;
				wb_addr = 5'd31;
				wb_sel = WB_LINK;
				pc_next = inst[core_pkg::IMEM_AW-1:0];
			end
			isa_pkg::OP_LW: begin
				alu_b = imm_s;
				wb_sel = WB_MEM;
				wb_en = lw_phase; // data arrives in second cycle.
				stall = !lw_phase;
			end
			isa_pkg::OP_SW: begin
				alu_b = imm_s;
				mem_we = 1'b1;
			end
			isa_pkg::OP_IN: begin
				wb_sel = WB_IN;
				wb_en = in_valid;
				stall = !in_valid;
			end
			isa_pkg::OP_OUT: stall = !out_ready;
			default: ;
		endcase
		if (stall) pc_next = pc;
	end

	always_comb begin
		case (wb_sel)
			WB_ALU: rf.wd = alu_result;
			WB_LINK: rf.wd = {{(32 - core_pkg::IMEM_AW){1'b0}}, pc_inc};
			WB_MEM: rf.wd = dmem.rdata;
			WB_IN: rf.wd = {24'b0, in_data};
			default: rf.wd = alu_result;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst || load_req) begin
			mode <= core_pkg::LOAD; // load_req wins over run_req.
			pc <= '0;
			lw_phase <= 1'b0;
		end else if (!exec) begin
			if (run_req) begin
				mode <= core_pkg::EXEC;
				pc <= '0;
			end
		end else begin
			pc <= pc_next;
			lw_phase <= op == isa_pkg::OP_LW && !lw_phase;
		end
	end
endmodule

//--- logic/core_ifs.sv
interface rf_if;
	logic [4:0] ra1;
	logic [4:0] ra2;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [4:0] wa;
	logic [31:0] wd;
	logic we;

	modport ctrl (
		output ra1, ra2, wa, wd, we,
		input rd1, rd2
	);
	modport rf (
		input ra1, ra2, wa, wd, we,
		output rd1, rd2
	);
endinterface

interface dmem_if;
	logic [core_pkg::DMEM_AW-1:0] addr;
	logic [31:0] wdata;
	logic we;
	logic [31:0] rdata; // valid one cycle after addr.

	modport ctrl (
		output addr, wdata, we,
		input rdata
	);
	modport mem (
		input addr, wdata, we,
		output rdata
	);
endinterface

//--- logic/core_pkg.sv
package core_pkg;

	localparam int IMEM_AW = 10; // instruction memory word address.
	localparam int DMEM_AW = 10; // data memory word address.

	typedef enum logic {
		LOAD,
		EXEC
	} mode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SLT,
		ALU_LUI // imm into upper half.
	} alu_op_e;

endpackage

//--- logic/cpu_top.sv
module cpu_top (
	input logic CLK,
	input logic rst,
	input logic load_req,
	input logic run_req,
	input logic [7:0] in_data,
	input logic in_valid,
	output logic in_ready,
	output logic [7:0] out_data,
	output logic out_valid,
	input logic out_ready,
	output logic running
);
	core_pkg::mode_e mode;
	core_pkg::alu_op_e alu_op;
	logic [core_pkg::IMEM_AW-1:0] fetch_addr;
	logic [31:0] inst;
	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic alu_eq;

	rf_if rf_bus();
	dmem_if dmem_bus();

	core_ctrl ctrl_i (
		.CLK(CLK),
		.rst(rst),
		.load_req(load_req),
		.run_req(run_req),
		.mode(mode),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.running(running),
		.fetch_addr(fetch_addr),
		.inst(inst),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_result(alu_result),
		.alu_eq(alu_eq),
		.rf(rf_bus.ctrl),
		.dmem(dmem_bus.ctrl)
	);

	prog_loader loader_i (
		.CLK(CLK),
		.rst(rst),
		.mode(mode),
		.in_data(in_data),
		.in_valid(in_valid),
		.fetch_addr(fetch_addr),
		.inst(inst)
	);

	reg_file rf_i (.CLK(CLK), .rf(rf_bus.rf));

	alu alu_i (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.shamt(inst[isa_pkg::SHAMT_LSB +: 5]),
		.result(alu_result),
		.eq(alu_eq)
	);

	data_mem dmem_i (.CLK(CLK), .mem(dmem_bus.mem));
endmodule

//--- logic/data_mem.sv
module data_mem (
	input logic CLK,
	dmem_if.mem mem
);
	logic [31:0] ram [2**core_pkg::DMEM_AW];

	always_ff @(posedge CLK) begin
		if (mem.we) begin
			ram[mem.addr] <= mem.wdata;
		end
		mem.rdata <= ram[mem.addr]; // one cycle read latency.
	end
endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

	// instruction field positions.
	localparam int OP_LSB    = 26;
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int SHAMT_LSB = 6;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_LSB   = 0;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDI    = 6'b001000,
		OP_SLTI    = 6'b001010,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_IN      = 6'b011010, // byte from input stream.
		OP_OUT     = 6'b011011, // byte to output stream.
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FUNCT_SLL  = 6'b000000,
		FUNCT_SRL  = 6'b000010,
		FUNCT_JR   = 6'b001000,
		FUNCT_JALR = 6'b001001,
		FUNCT_ADD  = 6'b100000,
		FUNCT_SUB  = 6'b100010,
		FUNCT_AND  = 6'b100100,
		FUNCT_OR   = 6'b100101,
		FUNCT_NOR  = 6'b100111,
		FUNCT_SLT  = 6'b101010
	} funct_e;

endpackage

//--- logic/prog_loader.sv
module prog_loader (
	input logic CLK,
	input logic rst,
	input core_pkg::mode_e mode,
	input logic [7:0] in_data,
	input logic in_valid,
	input logic [core_pkg::IMEM_AW-1:0] fetch_addr,
	output logic [31:0] inst
);
	logic [31:0] imem [2**core_pkg::IMEM_AW];
	logic [core_pkg::IMEM_AW-1:0] wr_addr;
	logic [1:0] byte_idx; // low byte first.
	logic load_byte;

	// in_ready is always high in load mode.
	assign load_byte = mode == core_pkg::LOAD && in_valid;

	always_ff @(posedge CLK) begin
		if (!rst && load_byte) begin
			imem[wr_addr][{byte_idx, 3'b000} +: 8] <= in_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_addr <= '0;
			byte_idx <= '0;
		end else if (mode == core_pkg::EXEC) begin
			wr_addr <= '0; // next load starts at word 0.
			byte_idx <= '0;
		end else if (load_byte) begin
			{wr_addr, byte_idx} <= {wr_addr, byte_idx} + 1'b1;
		end
	end

	assign inst = imem[fetch_addr];
endmodule

//--- logic/reg_file.sv
module reg_file (
	input logic CLK,
	rf_if.rf rf
);
	logic [31:0] regs [32];

	// r0 reads as zero whatever the array holds.
	assign rf.rd1 = rf.ra1 == 5'd0 ? 32'b0 : regs[rf.ra1];
	assign rf.rd2 = rf.ra2 == 5'd0 ? 32'b0 : regs[rf.ra2];

	always_ff @(posedge CLK) begin
		if (rf.we && rf.wa != 5'd0) begin
			regs[rf.wa] <= rf.wd;
		end
	end
endmodule

//--- sim/cpu_vectors.txt
// each token is one record: tag digit, then data byte in hex.
// tags: 0 program byte, 1 run, 2 input byte, 3 expected output, 4 end of test, 5 reload.
// echo loop: in r1, out r1, j 0.
500
000 000 001 068 000 000 001 06C 000 000 000 008
100 200 25A 2A5 2FF 23C 300 35A 3A5 3FF 33C 400
// arithmetic on a = 96, b = 2b.
500
000 000 001 068 000 000 002 068 020 018 022 000 000 000 003 06C // in in add out
022 018 041 000 000 000 003 06C 024 018 022 000 000 000 003 06C // sub out and out
025 018 022 000 000 000 003 06C 027 018 022 000 000 000 003 06C // or out nor out
0C0 018 002 000 000 000 003 06C 082 018 001 000 000 000 003 06C // sll out srl out
02A 018 041 000 000 000 003 06C 038 0FF 023 020 000 000 003 06C // slt out addi out
00F 0FF 023 030 000 000 003 06C 040 080 043 034 000 000 003 06C // andi out ori out
000 080 004 03C 002 01E 004 000 000 000 003 06C 005 000 083 028 // lui srl out slti
000 000 003 06C 01D 000 000 008 // out and halt
100 296 22B
3C1 395 302 3BF 340 358 325 301 3CE 306 36B 380 301 400
// control flow: sum 1..10 through jal/jr, then jalr link and beq skip.
500
000 000 001 068 000 000 002 034 008 000 000 00C 0FF 0FF 021 020 // in ori jal addi
0FE 0FF 020 014 000 000 002 06C 000 000 01F 06C 00A 000 000 008 // bne out out j
020 010 041 000 008 000 0E0 003 00E 000 005 034 009 0F8 0A0 000 // add jr ori jalr
00C 000 000 008 00D 000 000 008 000 000 01F 06C 002 000 000 010 // spare spare out beq
000 000 001 06C 000 000 005 06C 012 000 000 008 // skipped out halt
100 20A 337 303 30C 30E 400
// memory: sw then lw at 100, 101 and 3ff.
500
000 000 001 068 000 000 002 068 064 000 003 034 000 000 061 0AC // in in ori sw
001 000 062 0AC 020 020 022 000 0FF 003 004 0AC 001 000 065 08C // sw add sw lw
000 000 005 06C 000 000 066 08C 020 038 0C5 000 000 000 007 06C // out lw add out
0FF 003 008 08C 000 000 008 06C 00E 000 000 008 // lw out halt
100 27E 2D3 3D3 351 351 400

//--- sim/tb_cpu.sv
module tb_cpu;
	localparam int PASSES = 2;
	localparam int CYCLES_PER_RECORD = 200;

	logic CLK;
	logic rst;
	logic load_req;
	logic run_req;
	logic [7:0] in_data;
	logic in_valid;
	logic in_ready;
	logic [7:0] out_data;
	logic out_valid;
	logic out_ready;
	logic running;

	logic [11:0] vectors [512]; // tag in [11:8], byte in [7:0].
	int n_records;
	int seed;
	logic gaps; // random idle cycles on both streams.
	logic [7:0] in_q [$];
	logic [7:0] exp_q [$];

	cpu_top dut_i (
		.CLK(CLK),
		.rst(rst),
		.load_req(load_req),
		.run_req(run_req),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.running(running)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic check_value(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Regression failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic send_byte(input logic [7:0] value);
		logic offered;
		logic sent;
		offered = 1'b0;
		sent = 1'b0;
		while (!sent) begin
			@(negedge CLK);
			if (!offered && gaps && ($random(seed) & 3) == 0) begin
				in_valid = 1'b0;
			end else begin
				offered = 1'b1; // held until accepted.
				in_valid = 1'b1;
				in_data = value;
				sent = in_ready; // transfers on the next rising edge.
			end
		end
	endtask

	task automatic recv_byte(output logic [7:0] value);
		logic got;
		got = 1'b0;
		value = 8'h00;
		while (!got) begin
			@(negedge CLK);
			out_ready = !(gaps && ($random(seed) & 3) == 0);
			if (out_ready && out_valid) begin
				value = out_data;
				got = 1'b1;
			end
		end
	endtask

	task automatic start_run();
		@(negedge CLK);
		in_valid = 1'b0;
		run_req = 1'b1;
		@(negedge CLK);
		run_req = 1'b0;
		check_value("running", {7'b0, running}, 8'h01);
	endtask

	task automatic reload();
		@(negedge CLK);
		load_req = 1'b1;
		@(negedge CLK);
		load_req = 1'b0;
		check_value("running", {7'b0, running}, 8'h00);
	endtask

	task automatic run_test();
		fork
			begin
				while (in_q.size() > 0) send_byte(in_q.pop_front());
				@(negedge CLK);
				in_valid = 1'b0;
			end
			begin
				logic [7:0] actual;
				while (exp_q.size() > 0) begin
					recv_byte(actual);
					check_value("out_data", actual, exp_q.pop_front());
				end
				@(negedge CLK);
				out_ready = 1'b0;
			end
		join
		// every program ends idle or waiting on IN, so no byte may be pending.
		@(negedge CLK);
		check_value("out_valid", {7'b0, out_valid}, 8'h00);
	endtask

	task automatic play_vectors();
		logic [8:0] idx;
		logic [3:0] tag;
		logic [7:0] value;
		idx = 9'd0;
		while (int'(idx) < n_records) begin
			tag = vectors[idx][11:8];
			value = vectors[idx][7:0];
			case (tag)
				4'h0: send_byte(value);
				4'h1: start_run();
				4'h2: in_q.push_back(value);
				4'h3: exp_q.push_back(value);
				4'h4: run_test();
				4'h5: reload();
				default: begin
					$display("unknown record tag %h at record %0d", tag, idx);
					$display("Regression failed");
					$fatal(1, "bad vector file");
				end
			endcase
			idx++;
		end
	endtask

	initial begin
		logic [8:0] idx;
		rst = 1'b1;
		load_req = 1'b0;
		run_req = 1'b0;
		in_data = 8'h00;
		in_valid = 1'b0;
		out_ready = 1'b0;
		gaps = 1'b0;
		seed = 32'he3f19da2;
		n_records = 0;
		foreach (vectors[i]) vectors[i] = 12'hFFF; // tag f marks the end.
		$readmemh("sim/cpu_vectors.txt", vectors);
		idx = 9'd0;
		while (vectors[idx][11:8] != 4'hF && idx != 9'd511) idx++;
		n_records = int'(idx);
		if (n_records == 0) begin
			$display("vector file sim/cpu_vectors.txt is missing or empty");
			$display("Regression failed");
			$fatal(1, "no vectors");
		end
		repeat (10) @(negedge CLK);
		rst = 1'b0;
		play_vectors();
		gaps = 1'b1; // same programs again under back-pressure.
		play_vectors();
		$display("Regression passed");
		$finish;
	end

	initial begin
		wait (n_records > 0);
		repeat (n_records * PASSES * CYCLES_PER_RECORD) @(posedge CLK);
		$display("timeout: the core stalled before all %0d records were played", n_records);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end
endmodule
